// ==== hw/data_mem_router.sv ====
`timescale 1ns/1ns
`include "mem_access_cfg.svh"

module data_mem_router (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pop_valid,
    output logic                      pop_ready,
    input  mem_access_pkg::paddr_t    pop_paddr,
    input  mem_access_pkg::vaddr_t    pop_vaddr,
    input  logic                      pop_store,
    input  mem_access_pkg::wstrb_t    pop_wstrb,
    input  mem_access_pkg::word_t     pop_wdata,
    input  logic                      pop_uncached,
    input  logic                      pop_exception,
    input  mem_access_pkg::exc_code_t pop_exc_code,
    output logic                      unc_valid,
    input  logic                      unc_ready,
    output mem_access_pkg::paddr_t    unc_addr,
    output logic                      unc_we,
    output mem_access_pkg::wstrb_t    unc_wstrb,
    output mem_access_pkg::word_t     unc_wdata,
    input  mem_access_pkg::word_t     unc_rdata,
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output mem_access_pkg::word_t     resp_rdata,
    output logic                      resp_exception,
    output mem_access_pkg::exc_code_t resp_exc_code,
    output mem_access_pkg::vaddr_t    resp_badvaddr
);
    localparam int IDX_W = $clog2(`DMEM_WORDS);

    mem_access_pkg::router_state_t state;
    mem_access_pkg::word_t         dmem [`DMEM_WORDS];
    mem_access_pkg::paddr_t        cur_paddr;
    logic                          cur_store;
    mem_access_pkg::wstrb_t        cur_wstrb;
    mem_access_pkg::word_t         cur_wdata;
    logic [IDX_W-1:0]              pop_idx;
    logic [IDX_W-1:0]              cur_idx;
    logic                          pop_fire;
    logic                          ram_wr;

    assign pop_ready = state == mem_access_pkg::IDLE;
    assign pop_fire  = pop_valid && pop_ready;
    assign ram_wr    = pop_fire && !pop_exception && !pop_uncached && pop_store;
    assign pop_idx   = pop_paddr[IDX_W+1:2];  // word index
    assign cur_idx   = cur_paddr[IDX_W+1:2];

    assign unc_valid  = state == mem_access_pkg::UNC_WAIT;
    assign unc_addr   = cur_paddr;
    assign unc_we     = cur_store;
    assign unc_wstrb  = cur_wstrb;
    assign unc_wdata  = cur_wdata;
    assign resp_valid = state == mem_access_pkg::RESP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_access_pkg::IDLE;
        end else begin
            case (state)
                mem_access_pkg::IDLE: begin
                    if (pop_valid) begin
                        if (pop_exception || ram_wr) begin
                            state <= mem_access_pkg::RESP;
                        end else if (pop_uncached) begin
                            state <= mem_access_pkg::UNC_WAIT;
                        end else begin
                            state <= mem_access_pkg::RAM_RD;
                        end
                    end
                end
                mem_access_pkg::RAM_RD: state <= mem_access_pkg::RESP;
                mem_access_pkg::UNC_WAIT: begin
                    if (unc_ready) begin
                        state <= mem_access_pkg::RESP;
                    end
                end
                default: begin
                    if (resp_ready) begin
                        state <= mem_access_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (ram_wr && pop_wstrb[b]) begin
                dmem[pop_idx][8*b +: 8] <= pop_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_fire) begin
            cur_paddr      <= pop_paddr;
            cur_store      <= pop_store;
            cur_wstrb      <= pop_wstrb;
            cur_wdata      <= pop_wdata;
            resp_rdata     <= '0;
            resp_exception <= pop_exception;
            resp_exc_code  <= pop_exception ? pop_exc_code : '0;
            resp_badvaddr  <= pop_exception ? pop_vaddr : '0;
        end else if (state == mem_access_pkg::RAM_RD) begin
            resp_rdata <= dmem[cur_idx];
        end else if (unc_valid && unc_ready && !cur_store) begin
            resp_rdata <= unc_rdata;  // device data valid at handshake
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable({resp_rdata, resp_exception,
        resp_exc_code, resp_badvaddr}));

endmodule

// ==== hw/data_tlb.sv ====
`timescale 1ns/1ns
`include "mem_access_cfg.svh"

module data_tlb (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tlb_we,
    input  logic [$clog2(`TLB_ENTRIES)-1:0] tlb_index,
    input  mem_access_pkg::vpn_t            tlb_vpn,
    input  mem_access_pkg::pfn_t            tlb_pfn,
    input  logic                            tlb_v,
    input  logic                            tlb_d,
    input  mem_access_pkg::cattr_t          tlb_c,
    input  mem_access_pkg::vpn_t            s1_vpn,
    output logic                            s1_found,
    output logic                            s1_v,
    output logic                            s1_d,
    output mem_access_pkg::pfn_t            s1_pfn,
    output mem_access_pkg::cattr_t          s1_c
);
    logic [`TLB_ENTRIES-1:0] used;  // written since reset
    logic [`TLB_ENTRIES-1:0] hit;
    mem_access_pkg::vpn_t    vpn_q [`TLB_ENTRIES];
    mem_access_pkg::pfn_t    pfn_q [`TLB_ENTRIES];
    mem_access_pkg::cattr_t  c_q   [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] v_q;
    logic [`TLB_ENTRIES-1:0] d_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used <= '0;
        end else if (tlb_we) begin
            used[tlb_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            vpn_q[tlb_index] <= tlb_vpn;
            pfn_q[tlb_index] <= tlb_pfn;
            c_q[tlb_index]   <= tlb_c;
            v_q[tlb_index]   <= tlb_v;
            d_q[tlb_index]   <= tlb_d;
        end
    end

    // walk down so the lowest index wins
    always_comb begin
        s1_found = 1'b0;
        s1_v     = 1'b0;
        s1_d     = 1'b0;
        s1_pfn   = '0;
        s1_c     = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            hit[i] = used[i] && (vpn_q[i] == s1_vpn);
            if (hit[i]) begin
                s1_found = 1'b1;
                s1_v     = v_q[i];
                s1_d     = d_q[i];
                s1_pfn   = pfn_q[i];
                s1_c     = c_q[i];
            end
        end
    end

    // overlapping pages in the table
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit));

endmodule

// ==== hw/mem1_cache_prep.sv ====
`timescale 1ns/1ns
`include "mem_access_cfg.svh"

module mem1_cache_prep (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  mem_access_pkg::vaddr_t        req_vaddr,
    input  logic                          req_store,
    input  mem_access_pkg::mem_size_t     req_size,
    input  mem_access_pkg::word_t         req_wdata,
    output logic                          req_ready,
    input  mem_access_pkg::cattr_t        k0_mode,
    output mem_access_pkg::vpn_t          s1_vpn,
    input  logic                          s1_found,
    input  logic                          s1_v,
    input  logic                          s1_d,
    input  mem_access_pkg::pfn_t          s1_pfn,
    input  mem_access_pkg::cattr_t        s1_c,
    output logic                          push_valid,
    input  logic                          push_ready,
    output mem_access_pkg::paddr_t        push_paddr,
    output mem_access_pkg::vaddr_t        push_vaddr,
    output logic                          push_store,
    output mem_access_pkg::wstrb_t        push_wstrb,
    output mem_access_pkg::word_t         push_wdata,
    output logic                          push_uncached,
    output logic                          push_exception,
    output mem_access_pkg::exc_code_t     push_exc_code
);
    logic                      mapped;
    logic                      kseg0;
    logic                      kseg1;
    logic                      ade;
    logic                      tlb_inv;
    logic                      tlb_mod;
    logic                      uncached;
    logic                      exception;
    mem_access_pkg::exc_code_t exc_code;
    mem_access_pkg::paddr_t    paddr;
    mem_access_pkg::wstrb_t    wstrb;
    mem_access_pkg::word_t     wdata;

    assign s1_vpn = req_vaddr[31:12];
    assign mapped = !req_vaddr[31] || req_vaddr[30];  // kuseg, kseg2/3
    assign paddr  = mapped ? {s1_pfn, req_vaddr[11:0]} : {3'b000, req_vaddr[28:0]};

    assign ade     = (req_size == 2'd1 && req_vaddr[0]) || (req_size[1] && req_vaddr[1:0] != 2'b00);
    assign tlb_inv = mapped && (!s1_found || !s1_v);  // refill or invalid
    assign tlb_mod = mapped && req_store && s1_found && s1_v && !s1_d;

    always_comb begin
        exception = 1'b1;
        if (ade) begin
            exc_code = req_store ? `EXC_ADES : `EXC_ADEL;
        end else if (tlb_inv) begin
            exc_code = req_store ? `EXC_TLBS : `EXC_TLBL;
        end else if (tlb_mod) begin
            exc_code = `EXC_TLBMOD;
        end else begin
            exception = 1'b0;
            exc_code  = '0;
        end
    end

    assign kseg0    = req_vaddr[31:29] == 3'b100;
    assign kseg1    = req_vaddr[31:29] == 3'b101;
    assign uncached = kseg0 ? (k0_mode != 3'd3) : (kseg1 || s1_c != 3'd3);

    // lanes follow the low address bits
    always_comb begin
        case (req_size)
            2'd0: begin
                wstrb = 4'b0001 << req_vaddr[1:0];
                wdata = {4{req_wdata[7:0]}};
            end
            2'd1: begin
                wstrb = req_vaddr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{req_wdata[15:0]}};
            end
            default: begin
                wstrb = 4'b1111;
                wdata = req_wdata;
            end
        endcase
        if (!req_store) begin
            wstrb = 4'b0000;
        end
    end

    assign req_ready = !push_valid || push_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_valid <= 1'b0;
        end else if (req_ready) begin
            push_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            push_paddr     <= paddr;
            push_vaddr     <= req_vaddr;
            push_store     <= req_store;
            push_wstrb     <= wstrb;
            push_wdata     <= wdata;
            push_uncached  <= uncached;
            push_exception <= exception;
            push_exc_code  <= exc_code;
        end
    end

    // entry must not move while the fifo stalls it
    a_push_hold: assert property (@(posedge clk) disable iff (!rst_n)
        push_valid && !push_ready |=> push_valid && $stable({push_paddr, push_vaddr,
        push_store, push_wstrb, push_wdata, push_uncached, push_exception, push_exc_code}));

endmodule

// ==== hw/mem_access_pkg.sv ====
package mem_access_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;    // 3 means cacheable
    typedef logic [1:0]  mem_size_t; // 0 byte, 1 half, 2 word

    typedef enum logic [1:0] {
        IDLE,
        RAM_RD,
        UNC_WAIT,
        RESP
    } router_state_t;

endpackage

// ==== hw/mem_access_top.sv ====
`timescale 1ns/1ns
`include "mem_access_cfg.svh"

module mem_access_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  mem_access_pkg::vaddr_t          req_vaddr,
    input  logic                            req_store,
    input  mem_access_pkg::mem_size_t       req_size,
    input  mem_access_pkg::word_t           req_wdata,
    output logic                            resp_valid,
    input  logic                            resp_ready,
    output mem_access_pkg::word_t           resp_rdata,
    output logic                            resp_exception,
    output mem_access_pkg::exc_code_t       resp_exc_code,
    output mem_access_pkg::vaddr_t          resp_badvaddr,
    output logic                            unc_valid,
    input  logic                            unc_ready,
    output mem_access_pkg::paddr_t          unc_addr,
    output logic                            unc_we,
    output mem_access_pkg::wstrb_t          unc_wstrb,
    output mem_access_pkg::word_t           unc_wdata,
    input  mem_access_pkg::word_t           unc_rdata,
    input  logic                            tlb_we,
    input  logic [$clog2(`TLB_ENTRIES)-1:0] tlb_index,
    input  mem_access_pkg::vpn_t            tlb_vpn,
    input  mem_access_pkg::pfn_t            tlb_pfn,
    input  logic                            tlb_v,
    input  logic                            tlb_d,
    input  mem_access_pkg::cattr_t          tlb_c,
    input  mem_access_pkg::cattr_t          k0_mode
);
    // tlb lookup
    mem_access_pkg::vpn_t      s1_vpn;
    logic                      s1_found;
    logic                      s1_v;
    logic                      s1_d;
    mem_access_pkg::pfn_t      s1_pfn;
    mem_access_pkg::cattr_t    s1_c;

    // prep to fifo
    logic                      push_valid;
    logic                      push_ready;
    mem_access_pkg::paddr_t    push_paddr;
    mem_access_pkg::vaddr_t    push_vaddr;
    logic                      push_store;
    mem_access_pkg::wstrb_t    push_wstrb;
    mem_access_pkg::word_t     push_wdata;
    logic                      push_uncached;
    logic                      push_exception;
    mem_access_pkg::exc_code_t push_exc_code;

    // fifo to router
    logic                      pop_valid;
    logic                      pop_ready;
    mem_access_pkg::paddr_t    pop_paddr;
    mem_access_pkg::vaddr_t    pop_vaddr;
    logic                      pop_store;
    mem_access_pkg::wstrb_t    pop_wstrb;
    mem_access_pkg::word_t     pop_wdata;
    logic                      pop_uncached;
    logic                      pop_exception;
    mem_access_pkg::exc_code_t pop_exc_code;

    data_tlb u_tlb (.*);

    mem1_cache_prep u_prep (.*);

    mem_req_fifo u_fifo (.*);

    data_mem_router u_router (.*);

endmodule

// ==== hw/mem_req_fifo.sv ====
`timescale 1ns/1ns
`include "mem_access_cfg.svh"

module mem_req_fifo (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push_valid,
    output logic                      push_ready,
    input  mem_access_pkg::paddr_t    push_paddr,
    input  mem_access_pkg::vaddr_t    push_vaddr,
    input  logic                      push_store,
    input  mem_access_pkg::wstrb_t    push_wstrb,
    input  mem_access_pkg::word_t     push_wdata,
    input  logic                      push_uncached,
    input  logic                      push_exception,
    input  mem_access_pkg::exc_code_t push_exc_code,
    output logic                      pop_valid,
    input  logic                      pop_ready,
    output mem_access_pkg::paddr_t    pop_paddr,
    output mem_access_pkg::vaddr_t    pop_vaddr,
    output logic                      pop_store,
    output mem_access_pkg::wstrb_t    pop_wstrb,
    output mem_access_pkg::word_t     pop_wdata,
    output logic                      pop_uncached,
    output logic                      pop_exception,
    output mem_access_pkg::exc_code_t pop_exc_code
);
    localparam int PTR_W   = $clog2(`MEM_FIFO_DEPTH);
    localparam int ENTRY_W = 32 + 32 + 1 + 4 + 32 + 1 + 1 + 5;

    logic [ENTRY_W-1:0] mem [`MEM_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               push_fire;
    logic               pop_fire;

    assign push_ready = count != `MEM_FIFO_DEPTH;
    assign pop_valid  = count != 0;
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    assign {pop_paddr, pop_vaddr, pop_store, pop_wstrb, pop_wdata,
            pop_uncached, pop_exception, pop_exc_code} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= {push_paddr, push_vaddr, push_store, push_wstrb, push_wdata,
                            push_uncached, push_exception, push_exc_code};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(`MEM_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(`MEM_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // overflow or underflow shows up as a bad count
    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= `MEM_FIFO_DEPTH);
    a_ptr_match: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr == rd_ptr) == (count == 0 || count == `MEM_FIFO_DEPTH));

endmodule

// ==== include/mem_access_cfg.svh ====
`ifndef MEM_ACCESS_CFG_SVH
`define MEM_ACCESS_CFG_SVH

// sizing
`define MEM_FIFO_DEPTH 4
`define TLB_ENTRIES    8
`define DMEM_WORDS     256

// exception codes, cp0 cause encoding
`define EXC_TLBMOD 5'd1
`define EXC_TLBL   5'd2
`define EXC_TLBS   5'd3
`define EXC_ADEL   5'd4
`define EXC_ADES   5'd5

`endif

// ==== mem_access.f ====
+incdir+include
hw/mem_access_pkg.sv
hw/data_tlb.sv
hw/mem1_cache_prep.sv
hw/mem_req_fifo.sv
hw/data_mem_router.sv
hw/mem_access_top.sv
tb/tb_mem_access.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f mem_access.f --top-module tb_mem_access \
    -o tb_mem_access > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_mem_access > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== tb/tb_mem_access.sv ====
`timescale 1ns/1ns
`include "mem_access_cfg.svh"

module tb_mem_access;
    localparam int N_REQ          = 300;
    localparam int N_INIT         = 16;
    localparam int TIMEOUT_CYCLES = (N_REQ + N_INIT) * 40 + 100;

    logic                                clk;
    logic                                rst_n;
    logic                                req_valid;
    logic                                req_ready;
    mem_access_pkg::vaddr_t              req_vaddr;
    logic                                req_store;
    mem_access_pkg::mem_size_t           req_size;
    mem_access_pkg::word_t               req_wdata;
    logic                                resp_valid;
    logic                                resp_ready;
    mem_access_pkg::word_t               resp_rdata;
    logic                                resp_exception;
    mem_access_pkg::exc_code_t           resp_exc_code;
    mem_access_pkg::vaddr_t              resp_badvaddr;
    logic                                unc_valid;
    logic                                unc_ready;
    mem_access_pkg::paddr_t              unc_addr;
    logic                                unc_we;
    mem_access_pkg::wstrb_t              unc_wstrb;
    mem_access_pkg::word_t               unc_wdata;
    mem_access_pkg::word_t               unc_rdata;
    logic                                tlb_we;
    logic [$clog2(`TLB_ENTRIES)-1:0]     tlb_index;
    mem_access_pkg::vpn_t                tlb_vpn;
    mem_access_pkg::pfn_t                tlb_pfn;
    logic                                tlb_v;
    logic                                tlb_d;
    mem_access_pkg::cattr_t              tlb_c;
    mem_access_pkg::cattr_t              k0_mode;

    logic [31:0] lfsr;
    logic [31:0] rdy_bits;
    int          errors;
    int          checks;
    int          n_resp;
    int          n_sent;

    // reference model state
    logic [19:0] m_vpn [4];
    logic [19:0] m_pfn [4];
    logic        m_v [4];
    logic        m_d [4];
    logic [2:0]  m_c [4];
    logic [31:0] ram_shadow [`DMEM_WORDS];
    logic [31:0] dev_mem [logic [31:0]];     // the device itself
    logic [31:0] dev_shadow [logic [31:0]];  // model copy
    logic [31:0] exp_rdata_q [$];
    logic        exp_exc_q [$];
    logic [4:0]  exp_code_q [$];
    logic [31:0] exp_bad_q [$];
    logic [31:0] unc_addr_q [$];
    logic        unc_we_q [$];
    logic [3:0]  unc_strb_q [$];
    logic [31:0] unc_data_q [$];

    mem_access_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a96e1;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] r;
        int          b;
        r = old;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = data[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] dev_read(input logic [31:0] a);
        return dev_mem.exists(a) ? dev_mem[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] shadow_dev_read(input logic [31:0] a);
        return dev_shadow.exists(a) ? dev_shadow[a] : fill_word(a);
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_tlb(input logic [2:0] idx, input logic [19:0] vpn,
                             input logic [19:0] pfn, input logic v, input logic d,
                             input logic [2:0] c);
        tlb_we    = 1'b1;
        tlb_index = idx;
        tlb_vpn   = vpn;
        tlb_pfn   = pfn;
        tlb_v     = v;
        tlb_d     = d;
        tlb_c     = c;
        m_vpn[idx[1:0]] = vpn;
        m_pfn[idx[1:0]] = pfn;
        m_v[idx[1:0]]   = v;
        m_d[idx[1:0]]   = d;
        m_c[idx[1:0]]   = c;
        @(posedge clk);
        #2;
        tlb_we = 1'b0;
    endtask

    // expected response and device traffic for one request, in issue order
    task automatic model_req(input logic [31:0] va, input logic st, input logic [1:0] sz,
                             input logic [31:0] wd);
        logic        mapped;
        logic        misaligned;
        logic        found;
        logic        pv;
        logic        pd;
        logic        unc;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic [31:0] pa;
        logic [31:0] data;
        logic [31:0] word_a;
        logic [3:0]  strb;
        logic [4:0]  code;
        int          i;
        mapped = !va[31] || va[31:30] == 2'b11;
        found  = 1'b0;
        pv     = 1'b0;
        pd     = 1'b0;
        pfn    = '0;
        c      = '0;
        for (i = 3; i >= 0; i--) begin
            if (m_vpn[i] == va[31:12]) begin
                found = 1'b1;
                pv    = m_v[i];
                pd    = m_d[i];
                pfn   = m_pfn[i];
                c     = m_c[i];
            end
        end
        misaligned = (sz == 2'd1 && va[0]) || (sz == 2'd2 && va[1:0] != 2'b00);
        pa = mapped ? {pfn, va[11:0]} : {3'b000, va[28:0]};
        if (va[31:29] == 3'b100) begin
            unc = k0_mode != 3'd3;
        end else if (va[31:29] == 3'b101) begin
            unc = 1'b1;
        end else begin
            unc = c != 3'd3;
        end
        case (sz)
            2'd0: begin
                strb = 4'b0001 << va[1:0];
                data = {4{wd[7:0]}};
            end
            2'd1: begin
                strb = va[1] ? 4'b1100 : 4'b0011;
                data = {2{wd[15:0]}};
            end
            default: begin
                strb = 4'b1111;
                data = wd;
            end
        endcase
        code = '0;
        if (misaligned) begin
            code = st ? `EXC_ADES : `EXC_ADEL;
        end else if (mapped && !(found && pv)) begin
            code = st ? `EXC_TLBS : `EXC_TLBL;
        end else if (mapped && st && !pd) begin
            code = `EXC_TLBMOD;
        end
        word_a = {pa[31:2], 2'b00};
        exp_exc_q.push_back(code != 5'd0);
        exp_code_q.push_back(code);
        exp_bad_q.push_back(code != 5'd0 ? va : 32'd0);
        if (code != 5'd0 || st) begin
            exp_rdata_q.push_back(32'd0);
        end else if (unc) begin
            exp_rdata_q.push_back(shadow_dev_read(word_a));
        end else begin
            exp_rdata_q.push_back(ram_shadow[pa[9:2]]);
        end
        if (code == 5'd0 && unc) begin
            unc_addr_q.push_back(pa);
            unc_we_q.push_back(st);
            unc_strb_q.push_back(st ? strb : 4'b0000);
            unc_data_q.push_back(data);
            if (st) begin
                dev_shadow[word_a] = merge(shadow_dev_read(word_a), data, strb);
            end
        end else if (code == 5'd0 && st) begin
            ram_shadow[pa[9:2]] = merge(ram_shadow[pa[9:2]], data, strb);
        end
    endtask

    task automatic send_req(input logic [31:0] va, input logic st, input logic [1:0] sz,
                            input logic [31:0] wd);
        req_valid = 1'b1;
        req_vaddr = va;
        req_store = st;
        req_size  = sz;
        req_wdata = wd;
        model_req(va, st, sz, wd);
        n_sent++;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    function automatic logic [31:0] region_base(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd1: return 32'h8000_0000;  // kseg0
            3'd2:       return 32'ha000_0000;  // kseg1
            3'd3:       return 32'h0001_0000;  // valid, dirty, cached
            3'd4:       return 32'h0001_1000;  // valid, clean
            3'd5:       return 32'h0001_2000;  // uncached page
            3'd6:       return 32'hc000_0000;  // invalid entry
            default:    return 32'h0001_3000;  // not in the tlb
        endcase
    endfunction

    task automatic check_resp;
        if (exp_rdata_q.size() == 0) begin
            errors++;
            $display("response at %0t ns with no request outstanding", $time);
        end else begin
            n_resp++;
            check_val("resp_rdata", resp_rdata, exp_rdata_q.pop_front());
            check_val("resp_exception", {31'd0, resp_exception}, {31'd0, exp_exc_q.pop_front()});
            check_val("resp_exc_code", {27'd0, resp_exc_code}, {27'd0, exp_code_q.pop_front()});
            check_val("resp_badvaddr", resp_badvaddr, exp_bad_q.pop_front());
        end
    endtask

    task automatic device_access;
        logic        exp_we;
        logic [31:0] exp_data;
        logic [31:0] word_a;
        word_a = {unc_addr[31:2], 2'b00};
        if (unc_addr_q.size() == 0) begin
            errors++;
            $display("uncached access to %h at %0t ns that the model did not expect",
                     unc_addr, $time);
        end else begin
            exp_we   = unc_we_q.pop_front();
            exp_data = unc_data_q.pop_front();
            check_val("unc_addr", unc_addr, unc_addr_q.pop_front());
            check_val("unc_we", {31'd0, unc_we}, {31'd0, exp_we});
            check_val("unc_wstrb", {28'd0, unc_wstrb}, {28'd0, unc_strb_q.pop_front()});
            if (exp_we) begin
                check_val("unc_wdata", unc_wdata, exp_data);
            end
        end
        if (unc_we) begin
            dev_mem[word_a] = merge(dev_read(word_a), unc_wdata, unc_wstrb);
        end
    endtask

    // handshakes seen at negedge complete on the next rising edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (resp_valid && resp_ready) begin
                check_resp();
            end
            if (unc_valid && unc_ready) begin
                device_access();
            end
        end
    end

    // random back-pressure and the device read port
    always begin
        @(negedge clk);
        if (rst_n === 1'b1) begin
            take_bits(2, rdy_bits);
        end else begin
            rdy_bits = '0;
        end
        @(posedge clk);
        #2;
        resp_ready = rdy_bits[0];
        unc_ready  = rdy_bits[1];
        unc_rdata  = (unc_valid === 1'b1) ? dev_read({unc_addr[31:2], 2'b00}) : 32'd0;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d responses, checks %0d errors %0d",
                 TIMEOUT_CYCLES, n_resp, n_sent, checks, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wd;
        logic [2:0]  region;
        logic [5:0]  off;
        logic        st;
        logic [1:0]  sz;
        int          n;
        lfsr       = 32'h12725bc4;
        errors     = 0;
        checks     = 0;
        n_resp     = 0;
        n_sent     = 0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        req_store  = 1'b0;
        req_size   = '0;
        req_wdata  = '0;
        resp_ready = 1'b0;
        unc_ready  = 1'b0;
        unc_rdata  = '0;
        tlb_we     = 1'b0;
        tlb_index  = '0;
        tlb_vpn    = '0;
        tlb_pfn    = '0;
        tlb_v      = 1'b0;
        tlb_d      = 1'b0;
        tlb_c      = '0;
        k0_mode    = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n   = 1'b1;
        k0_mode = 3'd3;
        write_tlb(3'd0, 20'h00010, 20'h00100, 1'b1, 1'b1, 3'd3);
        write_tlb(3'd1, 20'h00011, 20'h00101, 1'b1, 1'b0, 3'd3);
        write_tlb(3'd2, 20'h00012, 20'h00200, 1'b1, 1'b1, 3'd2);
        write_tlb(3'd3, 20'hc0000, 20'h00300, 1'b0, 1'b1, 3'd3);
        // known contents for the local ram words in use
        for (n = 0; n < N_INIT; n++) begin
            send_req(32'h8000_0000 + 32'(4 * n), 1'b1, 2'd2, fill_word(32'(4 * n)));
        end
        for (n = 0; n < N_REQ; n++) begin
            take_bits(3, r);
            region = r[2:0];
            take_bits(6, r);
            off = r[5:0];
            take_bits(1, r);
            st = r[0];
            take_bits(2, r);
            sz = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
            take_bits(32, wd);
            send_req(region_base(region) | {26'd0, off}, st, sz, wd);
        end
        while (exp_rdata_q.size() != 0 || unc_addr_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        $display("checks %0d errors %0d responses %0d of %0d", checks, errors, n_resp, n_sent);
        if (errors == 0 && n_resp == n_sent) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
